/* vlog.f */
verilog/cpu_pkg.sv
verilog/fetch_unit.sv
verilog/reg_file.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/result_stage.sv
verilog/cpu_core.sv
tests/cpu_sva.sv
tests/cpu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cpu_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= vlog.f
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep "NO ERRORS" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

/* tests/cpu_tb.sv */
`timescale 1ns/100ps

module cpu_tb;
    import cpu_pkg::*;

    localparam logic [31:0] RESET_PC   = 32'hbfc00000;
    localparam int          SEED_WORDS = 16;   // lui/ori pairs plus the end loop
    localparam int          TOTAL_WORDS = 10 + 60 + 60 + 60 + 200 + 5 * SEED_WORDS;
    localparam int          CYCLE_LIMIT = TOTAL_WORDS * 8 + 200;

    logic        clk = 1'b0;
    logic        rst_n = 1'b0;
    logic        inst_sram_en, data_sram_en;
    logic [3:0]  inst_sram_wen, data_sram_wen, debug_wb_rf_wen;
    logic [31:0] inst_sram_addr, inst_sram_wdata, data_sram_addr, data_sram_wdata;
    logic [31:0] inst_sram_rdata = 32'd0;
    logic [31:0] data_sram_rdata = 32'd0;
    logic [31:0] debug_wb_pc, debug_wb_rf_wdata;
    logic [4:0]  debug_wb_rf_wnum;

    logic [31:0] imem [0:511];
    logic [31:0] dmem [0:15];
    logic [31:0] mm [0:15];     // model data memory
    logic [31:0] rm [0:31];     // model registers
    logic [31:0] exp_pc [$];
    logic [4:0]  exp_num [$];
    logic [31:0] exp_data [$];
    logic [31:0] lfsr = 32'h229b;
    logic        i_en_s, d_en_s, first_fetch;
    logic [3:0]  d_wen_s;
    logic [31:0] i_addr_s, d_addr_s, d_wdata_s;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          cycles = 0;
    int          stores_seen = 0;
    int          exp_stores = 0;

    cpu_core dut0 (.*);

    always #20 clk = ~clk;

    // --------------------
    // helpers

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};   // one step per bit
        end
        return v;
    endfunction

    function automatic logic [4:0] rand_reg();
        logic [31:0] t;
        t = rand_bits(3);
        return t[4:0];
    endfunction

    function automatic logic [15:0] rand_half();
        logic [31:0] t;
        t = rand_bits(16);
        return t[15:0];
    endfunction

    function automatic logic [31:0] enc_r(input funct_e f, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd,
                                          input logic [4:0] sh);
        return {6'h00, rs, rt, rd, sh, f};
    endfunction

    function automatic logic [31:0] enc_i(input opcode_e op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] imem_read(input logic [31:0] addr);
        logic [31:0] off;
        off = addr - RESET_PC;
        if (off < 32'd2048 && off[1:0] == 2'b00)
            return imem[off[10:2]];
        return NOP_WORD;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    // --------------------
    // sram models and trace checker

    always @(negedge clk) begin
        i_en_s    = inst_sram_en;
        i_addr_s  = inst_sram_addr;
        d_en_s    = data_sram_en;
        d_wen_s   = data_sram_wen;
        d_addr_s  = data_sram_addr;
        d_wdata_s = data_sram_wdata;
        if (first_fetch && inst_sram_en) begin
            compare("inst_sram_addr", inst_sram_addr, RESET_PC);
            first_fetch = 1'b0;
        end
        if (inst_sram_en)
            compare("inst_sram_wen", {28'd0, inst_sram_wen}, 32'd0);
        if (rst_n && debug_wb_rf_wen != 4'h0) begin
            if (exp_pc.size() == 0) begin
                errors++;
                $display("unexpected register write at %0t from pc %h", $time, debug_wb_pc);
            end else begin
                compare("debug_wb_pc", debug_wb_pc, exp_pc.pop_front());
                compare("debug_wb_rf_wnum", {27'd0, debug_wb_rf_wnum},
                        {27'd0, exp_num.pop_front()});
                compare("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_data.pop_front());
                compare("debug_wb_rf_wen", {28'd0, debug_wb_rf_wen}, 32'h0000_000f);
            end
        end
    end

    always @(posedge clk) begin
        #1;
        if (i_en_s)
            inst_sram_rdata = imem_read(i_addr_s);
        if (d_en_s) begin
            if (d_addr_s >= 32'd64) begin
                errors++;
                $display("data access outside the window at %0t, address %h", $time, d_addr_s);
            end else if (d_wen_s != 4'h0) begin
                dmem[d_addr_s[5:2]] = d_wdata_s;
                stores_seen++;
            end else
                data_sram_rdata = dmem[d_addr_s[5:2]];
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // --------------------
    // program generator

    task automatic gen_program(input int len, input int mask, output int last);
        int          idx, cls, kind, off;
        logic [4:0]  last_dest, s1, s2, d;
        logic        prev_br;
        logic [31:0] ofs;
        idx = 0;
        last_dest = 5'd1;
        prev_br = 1'b0;
        for (int i = 0; i < 512; i++)
            imem[i] = NOP_WORD;
        for (int r = 1; r < 8; r++) begin
            imem[idx]     = enc_i(OP_LUI, 5'd0, 5'(r), rand_half());
            imem[idx + 1] = enc_i(OP_ORI, 5'(r), 5'(r), rand_half());
            idx = idx + 2;
        end
        last = idx + len;
        for (int k = 0; k < len; k++) begin
            cls = rand_bits(2) % 3;
            if (((mask >> cls) & 1) == 0)
                cls = 0;
            if (cls == 2 && (k == len - 1 || prev_br))
                cls = 0;            // no branch in a delay slot
            s1 = rand_bits(1) ? last_dest : rand_reg();   // dependent half the time
            s2 = rand_bits(1) ? last_dest : rand_reg();
            d  = rand_reg();
            prev_br = (cls == 2);
            if (cls == 0) begin
                kind = rand_bits(4) % 10;
                case (kind)
                    0: imem[idx] = enc_r(F_ADDU, s1, s2, d, 5'd0);
                    1: imem[idx] = enc_r(F_SUBU, s1, s2, d, 5'd0);
                    2: imem[idx] = enc_r(F_AND, s1, s2, d, 5'd0);
                    3: imem[idx] = enc_r(F_OR, s1, s2, d, 5'd0);
                    4: imem[idx] = enc_r(F_XOR, s1, s2, d, 5'd0);
                    5: imem[idx] = enc_r(F_SLT, s1, s2, d, 5'd0);
                    6: imem[idx] = enc_r(F_SLL, 5'd0, s2, d, rand_reg() + 5'd1);
                    7: imem[idx] = enc_i(OP_ADDIU, s1, d, rand_half());
                    8: imem[idx] = enc_i(OP_ORI, s1, d, rand_half());
                    default: imem[idx] = enc_i(OP_LUI, 5'd0, d, rand_half());
                endcase
                last_dest = d;
            end else if (cls == 1) begin
                if (rand_bits(1)) begin
                    ofs = rand_bits(4);
                    imem[idx] = enc_i(OP_LW, 5'd0, d, {10'd0, ofs[3:0], 2'b00});
                    last_dest = d;
                end else begin
                    ofs = rand_bits(4);
                    imem[idx] = enc_i(OP_SW, 5'd0, s2, {10'd0, ofs[3:0], 2'b00});
                end
            end else begin
                off = 1 + int'(rand_bits(2));
                if (idx + 1 + off > last)
                    off = last - idx - 1;   // forward only and never past the end loop
                imem[idx] = enc_i(rand_bits(1) ? OP_BEQ : OP_BNE, s1, s2, 16'(off));
            end
            idx++;
        end
        imem[last]     = enc_i(OP_BEQ, 5'd0, 5'd0, 16'hffff);   // self loop
        imem[last + 1] = NOP_WORD;
    endtask

    // --------------------
    // isa reference model with delay slot

    task automatic run_model(input int last);
        int          pc, npc, tgt;
        logic [31:0] w, a, b, sx, res;
        logic [4:0]  dst;
        logic        wr, taken;
        for (int i = 0; i < 32; i++)
            rm[i] = 32'd0;
        for (int i = 0; i < 16; i++)
            mm[i] = dmem[i];
        exp_stores = 0;
        pc  = 0;
        npc = 1;
        while (pc != last) begin
            w     = imem[pc];
            a     = rm[w[25:21]];
            b     = rm[w[20:16]];
            sx    = {{16{w[15]}}, w[15:0]};
            dst   = w[20:16];
            res   = 32'd0;
            wr    = 1'b0;
            taken = 1'b0;
            case (w[31:26])
                OP_SPECIAL: begin
                    dst = w[15:11];
                    wr  = 1'b1;
                    case (w[5:0])
                        F_ADDU:  res = a + b;
                        F_SUBU:  res = a - b;
                        F_AND:   res = a & b;
                        F_OR:    res = a | b;
                        F_XOR:   res = a ^ b;
                        F_SLT:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        F_SLL:   res = b << w[10:6];
                        default: wr = 1'b0;
                    endcase
                end
                OP_ADDIU: begin res = a + sx; wr = 1'b1; end
                OP_ORI:   begin res = a | {16'd0, w[15:0]}; wr = 1'b1; end
                OP_LUI:   begin res = {w[15:0], 16'd0}; wr = 1'b1; end
                OP_LW:    begin res = mm[(a + sx) >> 2 & 32'hf]; wr = 1'b1; end
                OP_SW: begin
                    mm[(a + sx) >> 2 & 32'hf] = b;
                    exp_stores++;
                end
                OP_BEQ:   taken = (a == b);
                OP_BNE:   taken = (a != b);
                default:  ;
            endcase
            if (wr && dst != 5'd0) begin
                rm[dst] = res;
                exp_pc.push_back(RESET_PC + 32'(pc * 4));
                exp_num.push_back(dst);
                exp_data.push_back(res);
            end
            tgt = pc + 1 + int'($signed(w[15:0]));
            pc  = npc;
            npc = taken ? tgt : npc + 1;
        end
    endtask

    // --------------------
    // test sequence

    task automatic run_test(input string name, input int len, input int mask);
        int          err0, last;
        logic [31:0] addr;
        err0 = errors;
        @(posedge clk);
        #1 rst_n = 1'b0;
        for (int c = 0; c < 9; c++) begin
            @(posedge clk);
            @(negedge clk);
            if (c == 0) begin
                gen_program(len, mask, last);
                for (int i = 0; i < 16; i++) begin
                    addr = 32'(i * 4);
                    dmem[i] = {addr[15:0], ~addr[15:0]};
                end
                stores_seen = 0;
                run_model(last);
            end
            compare("data_sram_en", {31'd0, data_sram_en}, 32'd0);
            compare("data_sram_wen", {28'd0, data_sram_wen}, 32'd0);
            compare("debug_wb_rf_wen", {28'd0, debug_wb_rf_wen}, 32'd0);
        end
        @(posedge clk);
        #1 rst_n = 1'b1;
        first_fetch = 1'b1;
        @(negedge clk);
        compare("data_sram_en", {31'd0, data_sram_en}, 32'd0);
        compare("data_sram_wen", {28'd0, data_sram_wen}, 32'd0);
        compare("debug_wb_rf_wen", {28'd0, debug_wb_rf_wen}, 32'd0);
        // stores can still be in flight behind the last register write
        while (exp_pc.size() != 0 || stores_seen < exp_stores)
            @(negedge clk);
        for (int i = 0; i < 16; i++)
            compare($sformatf("dmem[%0d]", i), dmem[i], mm[i]);
        tests++;
        $display("test %s: %s, %0d errors", name, (errors == err0) ? "ok" : "failed",
                 errors - err0);
    endtask

    initial begin
        first_fetch = 1'b0;
        run_test("reset state", 10, 1);
        run_test("alu and immediate", 60, 1);
        run_test("loads and stores", 60, 3);
        run_test("branches", 60, 5);
        run_test("long mixed", 200, 7);
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* tests/cpu_sva.sv */
`timescale 1ns/100ps

module cpu_sva (
    input logic        clk,
    input logic        rst_n,
    input logic        inst_sram_en,
    input logic [31:0] inst_sram_addr,
    input logic        data_sram_en,
    input logic [3:0]  data_sram_wen,
    input logic [3:0]  debug_wb_rf_wen,
    input logic [4:0]  debug_wb_rf_wnum,
    input logic        stall
);

    // --------------------
    // port rules

    wen_needs_en: assert property (@(posedge clk) disable iff (!rst_n)
        data_sram_wen != 4'h0 |-> data_sram_en)
        else $error("data_sram_wen set without data_sram_en");

    no_trace_to_zero: assert property (@(posedge clk) disable iff (!rst_n)
        debug_wb_rf_wen != 4'h0 |-> debug_wb_rf_wnum != 5'd0)
        else $error("trace write to register 0");

    fetch_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        inst_sram_en |-> inst_sram_addr[1:0] == 2'b00)
        else $error("unaligned instruction address");

    // load-use bubble is a single cycle
    stall_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> !stall)
        else $error("stall held for more than one cycle");

endmodule

bind cpu_core cpu_sva sva0 (
    .clk              (clk),
    .rst_n            (rst_n),
    .inst_sram_en     (inst_sram_en),
    .inst_sram_addr   (inst_sram_addr),
    .data_sram_en     (data_sram_en),
    .data_sram_wen    (data_sram_wen),
    .debug_wb_rf_wen  (debug_wb_rf_wen),
    .debug_wb_rf_wnum (debug_wb_rf_wnum),
    .stall            (stall)
);

/* verilog/cpu_core.sv */
`timescale 1ns/100ps

module cpu_core #(
    parameter logic [31:0] reset_pc = 32'hbfc00000
) (
    input  logic        clk,
    input  logic        rst_n,
    // instruction sram
    output logic        inst_sram_en,
    output logic [3:0]  inst_sram_wen,
    output logic [31:0] inst_sram_addr,
    output logic [31:0] inst_sram_wdata,
    input  logic [31:0] inst_sram_rdata,
    // data sram
    output logic        data_sram_en,
    output logic [3:0]  data_sram_wen,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    input  logic [31:0] data_sram_rdata,
    // writeback trace
    output logic [31:0] debug_wb_pc,
    output logic [3:0]  debug_wb_rf_wen,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);
    import cpu_pkg::*;

    // --------------------
    // stage links

    logic [31:0] fetch_pc;
    logic        stall;
    logic        branch_taken;
    logic [31:0] branch_target;
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [31:0] rdata_a;
    logic [31:0] rdata_b;
    id_ex_t      id_ex;
    ex_wb_t      ex_wb;
    ex_fwd_t     ex_fwd;
    reg_write_t  wr;

    fetch_unit #(
        .reset_pc (reset_pc)
    ) u_fetch (
        .clk             (clk),
        .rst_n           (rst_n),
        .stall           (stall),
        .branch_taken    (branch_taken),
        .branch_target   (branch_target),
        .fetch_pc        (fetch_pc),
        .inst_sram_en    (inst_sram_en),
        .inst_sram_wen   (inst_sram_wen),
        .inst_sram_addr  (inst_sram_addr),
        .inst_sram_wdata (inst_sram_wdata)
    );

    decode_stage u_decode (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr         (inst_sram_rdata),
        .fetch_pc      (fetch_pc),
        .rdata_a       (rdata_a),
        .rdata_b       (rdata_b),
        .ex_fwd        (ex_fwd),
        .ra            (ra),
        .rb            (rb),
        .stall         (stall),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .id_ex         (id_ex)
    );

    reg_file u_rf (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr      (wr),
        .ra      (ra),
        .rb      (rb),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b)
    );

    execute_stage u_execute (
        .clk             (clk),
        .rst_n           (rst_n),
        .id_ex           (id_ex),
        .ex_fwd          (ex_fwd),
        .data_sram_en    (data_sram_en),
        .data_sram_wen   (data_sram_wen),
        .data_sram_addr  (data_sram_addr),
        .data_sram_wdata (data_sram_wdata),
        .ex_wb           (ex_wb)
    );

    result_stage u_result (
        .clk               (clk),
        .rst_n             (rst_n),
        .ex_wb             (ex_wb),
        .data_sram_rdata   (data_sram_rdata),
        .wr                (wr),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

endmodule

/* verilog/result_stage.sv */
`timescale 1ns/100ps

module result_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  cpu_pkg::ex_wb_t     ex_wb,
    input  logic [31:0]         data_sram_rdata,
    output cpu_pkg::reg_write_t wr,
    output logic [31:0]         debug_wb_pc,
    output logic [3:0]          debug_wb_rf_wen,
    output logic [4:0]          debug_wb_rf_wnum,
    output logic [31:0]         debug_wb_rf_wdata
);
    import cpu_pkg::*;

    logic [31:0] wb_data;
    logic        wb_en;

    // load data arrives this cycle, one after the request
    assign wb_data = (ex_wb.wb_sel == WB_MEM) ? data_sram_rdata : ex_wb.alu_result;

    // $0 never written
    assign wb_en = ex_wb.valid && ex_wb.reg_write && (ex_wb.dest != 5'd0);

    // --------------------
    // register file write

    assign wr.en   = wb_en;
    assign wr.dest = ex_wb.dest;
    assign wr.data = wb_data;

    // --------------------
    // debug trace, one cycle behind the write

    always_ff @(posedge clk) begin
        if (!rst_n)
            debug_wb_rf_wen <= 4'h0;
        else
            debug_wb_rf_wen <= {4{wb_en}};
    end

    always_ff @(posedge clk) begin
        debug_wb_pc       <= ex_wb.pc;
        debug_wb_rf_wnum  <= ex_wb.dest;
        debug_wb_rf_wdata <= wb_data;
    end

endmodule

/* verilog/execute_stage.sv */
`timescale 1ns/100ps

module execute_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_pkg::id_ex_t   id_ex,
    output cpu_pkg::ex_fwd_t  ex_fwd,
    output logic              data_sram_en,
    output logic [3:0]        data_sram_wen,
    output logic [31:0]       data_sram_addr,
    output logic [31:0]       data_sram_wdata,
    output cpu_pkg::ex_wb_t   ex_wb
);
    import cpu_pkg::*;

    logic [31:0] alu_y;
    ex_wb_t      ex_wb_d;

    // --------------------
    // alu

    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD: alu_y = id_ex.op_a + id_ex.op_b;
            ALU_SUB: alu_y = id_ex.op_a - id_ex.op_b;
            ALU_AND: alu_y = id_ex.op_a & id_ex.op_b;
            ALU_OR:  alu_y = id_ex.op_a | id_ex.op_b;
            ALU_XOR: alu_y = id_ex.op_a ^ id_ex.op_b;
            ALU_SLT: alu_y = {31'd0, $signed(id_ex.op_a) < $signed(id_ex.op_b)};
            ALU_SLL: alu_y = id_ex.op_b << id_ex.op_a[4:0];
            ALU_LUI: alu_y = {id_ex.op_b[15:0], 16'h0000};
            default: alu_y = 32'd0;
        endcase
    end

    // --------------------
    // data sram request, word only

    assign data_sram_en    = id_ex.valid && (id_ex.mem_read || id_ex.mem_write);
    assign data_sram_wen   = (id_ex.valid && id_ex.mem_write) ? 4'hf : 4'h0;
    assign data_sram_addr  = alu_y;    // base plus sign extended offset
    assign data_sram_wdata = id_ex.store_data;

    // back to decode for forwarding
    assign ex_fwd.wr.en   = id_ex.valid && id_ex.reg_write && (id_ex.dest != 5'd0);
    assign ex_fwd.wr.dest = id_ex.dest;
    assign ex_fwd.wr.data = alu_y;
    assign ex_fwd.is_load = id_ex.mem_read;

    always_comb begin
        ex_wb_d.valid      = id_ex.valid;
        ex_wb_d.pc         = id_ex.pc;
        ex_wb_d.alu_result = alu_y;
        ex_wb_d.wb_sel     = id_ex.wb_sel;
        ex_wb_d.reg_write  = id_ex.reg_write;
        ex_wb_d.dest       = id_ex.dest;
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            ex_wb <= '0;
        else
            ex_wb <= ex_wb_d;
    end

endmodule

/* verilog/decode_stage.sv */
`timescale 1ns/100ps

module decode_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [31:0]       instr,
    input  logic [31:0]       fetch_pc,
    input  logic [31:0]       rdata_a,
    input  logic [31:0]       rdata_b,
    input  cpu_pkg::ex_fwd_t  ex_fwd,
    output logic [4:0]        ra,
    output logic [4:0]        rb,
    output logic              stall,
    output logic              branch_taken,
    output logic [31:0]       branch_target,
    output cpu_pkg::id_ex_t   id_ex
);
    import cpu_pkg::*;

    logic        boot_q;
    logic        valid_q;
    logic        held_q;
    logic [31:0] instr_hold_q;
    logic [31:0] pc_hold_q;
    logic [31:0] ir;
    logic [31:0] pc;
    opcode_e     op;
    funct_e      fn;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [31:0] imm_sx;
    logic [31:0] src_a;
    logic [31:0] src_b;
    logic        use_rs;
    logic        use_rt;
    logic        is_beq;
    logic        is_bne;
    logic        ops_equal;
    id_ex_t      id_ex_d;

    // word from the sram is dropped until the first enabled fetch returns
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            boot_q  <= 1'b0;
            valid_q <= 1'b0;
            held_q  <= 1'b0;
        end else begin
            boot_q  <= 1'b1;
            valid_q <= boot_q;
            held_q  <= stall;
        end
    end

    always_ff @(posedge clk) begin
        instr_hold_q <= ir;
        pc_hold_q    <= pc;
    end

    assign ir     = held_q ? instr_hold_q : instr;  // sram already moved on
    assign pc     = held_q ? pc_hold_q : fetch_pc;
    assign op     = opcode_e'(ir[31:26]);
    assign fn     = funct_e'(ir[5:0]);
    assign rs     = ir[25:21];
    assign rt     = ir[20:16];
    assign imm_sx = {{16{ir[15]}}, ir[15:0]};
    assign ra     = rs;
    assign rb     = rt;

    // --------------------
    // forwarding and hazards

    assign src_a = (ex_fwd.wr.en && ex_fwd.wr.dest == rs) ? ex_fwd.wr.data : rdata_a;
    assign src_b = (ex_fwd.wr.en && ex_fwd.wr.dest == rt) ? ex_fwd.wr.data : rdata_b;

    assign stall = valid_q && ex_fwd.wr.en && ex_fwd.is_load &&
                   ((use_rs && ex_fwd.wr.dest == rs) || (use_rt && ex_fwd.wr.dest == rt));

    assign ops_equal     = (src_a == src_b);
    assign branch_taken  = valid_q && !stall &&
                           ((is_beq && ops_equal) || (is_bne && !ops_equal));
    assign branch_target = pc + 32'd4 + {imm_sx[29:0], 2'b00};  // from the delay slot

    // --------------------
    // field decode

    always_comb begin
        id_ex_d            = '0;
        id_ex_d.valid      = valid_q && !stall;   // bubble while stalled
        id_ex_d.pc         = pc;
        id_ex_d.alu_op     = ALU_ADD;
        id_ex_d.op_a       = src_a;
        id_ex_d.op_b       = src_b;
        id_ex_d.store_data = src_b;
        id_ex_d.wb_sel     = WB_ALU;
        id_ex_d.dest       = ir[15:11];
        use_rs = 1'b0;
        use_rt = 1'b0;
        is_beq = 1'b0;
        is_bne = 1'b0;
        case (op)
            OP_SPECIAL: begin
                use_rs            = 1'b1;
                use_rt            = 1'b1;
                id_ex_d.reg_write = 1'b1;
                case (fn)
                    F_ADDU: id_ex_d.alu_op = ALU_ADD;
                    F_SUBU: id_ex_d.alu_op = ALU_SUB;
                    F_AND:  id_ex_d.alu_op = ALU_AND;
                    F_OR:   id_ex_d.alu_op = ALU_OR;
                    F_XOR:  id_ex_d.alu_op = ALU_XOR;
                    F_SLT:  id_ex_d.alu_op = ALU_SLT;
                    F_SLL: begin
                        id_ex_d.alu_op = ALU_SLL;
                        id_ex_d.op_a   = {27'd0, ir[10:6]};
                        use_rs         = 1'b0;
                    end
                    default: id_ex_d.reg_write = 1'b0;
                endcase
            end
            OP_ADDIU, OP_ORI, OP_LUI, OP_LW: begin
                use_rs            = (op != OP_LUI);
                id_ex_d.reg_write = 1'b1;
                id_ex_d.dest      = rt;
                id_ex_d.op_b      = imm_sx;
                if (op == OP_ORI || op == OP_LUI)
                    id_ex_d.op_b = {16'd0, ir[15:0]};   // zero extended
                if (op == OP_ORI)
                    id_ex_d.alu_op = ALU_OR;
                if (op == OP_LUI)
                    id_ex_d.alu_op = ALU_LUI;
                if (op == OP_LW) begin
                    id_ex_d.mem_read = 1'b1;
                    id_ex_d.wb_sel   = WB_MEM;
                end
            end
            OP_SW: begin
                use_rs            = 1'b1;
                use_rt            = 1'b1;
                id_ex_d.op_b      = imm_sx;
                id_ex_d.mem_write = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                use_rs = 1'b1;
                use_rt = 1'b1;
                is_beq = (op == OP_BEQ);
                is_bne = (op == OP_BNE);
            end
            default: ;   // unknown, nop
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            id_ex <= '0;
        else
            id_ex <= id_ex_d;
    end

endmodule

/* verilog/reg_file.sv */
`timescale 1ns/100ps

module reg_file (
    input  logic                clk,
    input  logic                rst_n,
    input  cpu_pkg::reg_write_t wr,
    input  logic [4:0]          ra,
    input  logic [4:0]          rb,
    output logic [31:0]         rdata_a,
    output logic [31:0]         rdata_b
);

    logic [31:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (rst_n && wr.en && wr.dest != 5'd0)
            regs[wr.dest] <= wr.data;
    end

    // --------------------
    // read ports, new data wins on a same-cycle write

    always_comb begin
        if (ra == 5'd0)
            rdata_a = 32'd0;
        else if (wr.en && wr.dest == ra)
            rdata_a = wr.data;
        else
            rdata_a = regs[ra];

        if (rb == 5'd0)
            rdata_b = 32'd0;
        else if (wr.en && wr.dest == rb)
            rdata_b = wr.data;
        else
            rdata_b = regs[rb];
    end

endmodule

/* verilog/fetch_unit.sv */
`timescale 1ns/100ps

module fetch_unit #(
    parameter logic [31:0] reset_pc = 32'hbfc00000
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        stall,
    input  logic        branch_taken,
    input  logic [31:0] branch_target,
    output logic [31:0] fetch_pc,
    output logic        inst_sram_en,
    output logic [3:0]  inst_sram_wen,
    output logic [31:0] inst_sram_addr,
    output logic [31:0] inst_sram_wdata
);
    import cpu_pkg::*;

    logic [31:0] pc_q;      // address being issued
    logic [31:0] next_pc;
    logic        en_q;

    // hold on stall, redirect after the delay slot
    always_comb begin
        if (stall)
            next_pc = pc_q;
        else if (branch_taken)
            next_pc = branch_target;
        else
            next_pc = pc_q + 32'd4;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= reset_pc;
            en_q <= 1'b0;
        end else begin
            en_q <= 1'b1;
            if (en_q)
                pc_q <= next_pc;  // first enabled address stays reset_pc
        end
    end

    // pc of the word returning from the sram now
    always_ff @(posedge clk) begin
        fetch_pc <= pc_q;
    end

    assign inst_sram_en    = en_q;
    assign inst_sram_wen   = 4'h0;      // read only
    assign inst_sram_addr  = pc_q;
    assign inst_sram_wdata = NOP_WORD;

endmodule

/* verilog/cpu_pkg.sv */
package cpu_pkg;

    // --------------------
    // instruction encodings

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    // function field, special opcode only
    typedef enum logic [5:0] {
        F_SLL  = 6'h00,
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_SLT  = 6'h2a
    } funct_e;

    // sll $0,$0,0
    localparam logic [31:0] NOP_WORD = 32'h0000_0000;

    // --------------------
    // internal controls

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_LUI
    } alu_op_e;

    typedef enum logic {
        WB_ALU,
        WB_MEM
    } wb_sel_e;

    // --------------------
    // pipeline registers

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        alu_op_e     alu_op;
        logic [31:0] op_a;       // shamt for sll
        logic [31:0] op_b;       // immediate for i-type
        logic [31:0] store_data;
        logic        mem_read;
        logic        mem_write;
        wb_sel_e     wb_sel;
        logic        reg_write;
        logic [4:0]  dest;
    } id_ex_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] alu_result;
        wb_sel_e     wb_sel;
        logic        reg_write;
        logic [4:0]  dest;
    } ex_wb_t;

    typedef struct packed {
        logic        en;
        logic [4:0]  dest;
        logic [31:0] data;
    } reg_write_t;

    // execute result seen by decode
    typedef struct packed {
        reg_write_t  wr;
        logic        is_load;  // data not ready yet
    } ex_fwd_t;

endpackage
